// ==== logic/yarvi_pkg.sv ====
// Shared encodings for the integer execute path.
// Opcode values are the RV32I/RV64I major opcodes with the low two bits 11.
// Only the opcodes this path executes are listed; anything else is illegal.

package yarvi_pkg;

  // Default register width.
  parameter int default_xlen = 64;

  // Major opcodes handled by the execute path.
  typedef enum logic [6:0] {
    OPC_OP_IMM    = 7'b0010011,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_OP        = 7'b0110011,
    OPC_LUI       = 7'b0110111,
    OPC_OP_32     = 7'b0111011
  } opcode_e;

  // ALU selection, same values as funct3 in the ISA.
  typedef enum logic [2:0] {
    FN_ADDSUB = 3'd0,
    FN_SLL    = 3'd1,
    FN_SLT    = 3'd2,
    FN_SLTU   = 3'd3,
    FN_XOR    = 3'd4,
    // Logical or arithmetic, picked by insn bit 30.
    FN_SR     = 3'd5,
    FN_OR     = 3'd6,
    FN_AND    = 3'd7
  } alu_fn_e;

endpackage

// ==== logic/yarvi_alu.sv ====
// Purely combinational integer ALU.
// xlen must be 32 or 64; w is ignored when xlen is 32.
// Word ops take shift amounts from op2[4:0] and sign-extend from bit 31.

`timescale 1ns/1ps

module yarvi_alu #(
  parameter int xlen = 64
) (
  input  logic                insn30,
  input  yarvi_pkg::alu_fn_e  fn,
  input  logic                w,
  input  logic [xlen-1:0]     op1,
  input  logic [xlen-1:0]     op2,
  output logic [xlen-1:0]     result
);
  import yarvi_pkg::*;

  localparam int shw = $clog2(xlen);

  // Word forms only exist on the 64-bit datapath.
  logic                  w_eff;
  logic [shw-1:0]        shamt;
  logic [xlen-1:0]       sum;
  logic signed [xlen:0]  sr_full;
  logic signed [32:0]    sr_word;
  logic [xlen-1:0]       res;

  assign w_eff = w && (xlen == 64);

  // Five-bit amount for word shifts.
  assign shamt = w_eff ? shw'(op2[4:0]) : op2[shw-1:0];

  // Subtract as op1 + ~op2 + 1.
  assign sum = op1 + (op2 ^ {xlen{insn30}}) + xlen'(insn30);

  // Extra top bit carries the fill value for the right shift.
  assign sr_full = $signed({op1[xlen-1] & insn30, op1}) >>> shamt;
  assign sr_word = $signed({op1[31] & insn30, op1[31:0]}) >>> op2[4:0];

  always_comb begin
    case (fn)
      FN_ADDSUB: res = sum;
      FN_SLL:    res = op1 << shamt;
      FN_SLT:    res = {{(xlen-1){1'b0}}, $signed(op1) < $signed(op2)};
      FN_SLTU:   res = {{(xlen-1){1'b0}}, op1 < op2};
      FN_XOR:    res = op1 ^ op2;
      FN_SR:     res = w_eff ? xlen'(sr_word[31:0]) : sr_full[xlen-1:0];
      FN_OR:     res = op1 | op2;
      FN_AND:    res = op1 & op2;
      default:   res = '0;
    endcase
  end

  // Word results are sign-extended from bit 31.
  assign result = w_eff ? xlen'($signed(res[31:0])) : res;

endmodule

// ==== logic/yarvi_decode.sv ====
// Instruction decoder for OP, OP-IMM, LUI and the 64-bit word forms.
// Purely combinational; register fields are passed through undecoded.
// bad flags any encoding outside this subset and W ops at xlen 32.

`timescale 1ns/1ps

module yarvi_decode #(
  parameter int xlen = 64
) (
  input  logic [31:0]         insn,
  output logic [4:0]          rs1,
  output logic [4:0]          rs2,
  output logic [4:0]          rd,
  output yarvi_pkg::alu_fn_e  fn,
  output logic                alt,
  output logic                w,
  output logic                use_imm,
  output logic                is_lui,
  output logic                bad,
  output logic [xlen-1:0]     imm
);
  import yarvi_pkg::*;

  opcode_e     opc;
  logic [6:0]  funct7;
  logic        is_shift;
  // funct7 of 0, or 0x20 where the function has an alternate form.
  logic        f7_ok;

  assign opc    = opcode_e'(insn[6:0]);
  assign funct7 = insn[31:25];
  assign rd     = insn[11:7];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  // LUI always takes the adder.
  assign fn     = (opc == OPC_LUI) ? FN_ADDSUB : alu_fn_e'(insn[14:12]);

  assign is_shift = (fn == FN_SLL) || (fn == FN_SR);
  assign f7_ok    = (funct7 == 7'h00) ||
                    (funct7 == 7'h20 && (fn == FN_ADDSUB || fn == FN_SR));

  always_comb begin
    // Defaults cover the register-register forms.
    alt     = insn[30];
    w       = 1'b0;
    use_imm = 1'b0;
    is_lui  = 1'b0;
    bad     = 1'b0;
    // Sign-extended I-type immediate.
    imm     = xlen'($signed(insn[31:20]));
    case (opc)
      OPC_OP: begin
        bad = !f7_ok;
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        // Bit 30 is immediate data except on shifts.
        alt = is_shift & insn[30];
        if (fn == FN_SLL) begin
          bad = (xlen == 64) ? (insn[31:26] != 6'd0) : (funct7 != 7'h00);
        end else if (fn == FN_SR) begin
          // Six-bit shamt on RV64 makes insn[25] part of the amount.
          if (xlen == 64)
            bad = insn[31] || (insn[29:26] != 4'd0);
          else
            bad = (funct7 != 7'h00) && (funct7 != 7'h20);
        end
      end
      OPC_OP_32: begin
        w   = 1'b1;
        bad = (xlen == 32) || !f7_ok ||
              !(fn == FN_ADDSUB || fn == FN_SLL || fn == FN_SR);
      end
      OPC_OP_IMM_32: begin
        w       = 1'b1;
        use_imm = 1'b1;
        alt     = is_shift & insn[30];
        // ADDIW, SLLIW, SRLIW and SRAIW only.
        if (fn == FN_ADDSUB)
          bad = (xlen == 32);
        else if (is_shift)
          bad = (xlen == 32) || !(funct7 == 7'h00 || (fn == FN_SR && funct7 == 7'h20));
        else
          bad = 1'b1;
      end
      OPC_LUI: begin
        // Executed as 0 + imm.
        use_imm = 1'b1;
        is_lui  = 1'b1;
        alt     = 1'b0;
        imm     = xlen'($signed({insn[31:12], 12'h000}));
      end
      default: begin
        bad = 1'b1;
      end
    endcase
  end

endmodule

// ==== logic/yarvi_regfile.sv ====
// Integer register file with 31 storage entries and a hardwired x0.
// Two combinational read ports and one write port.
// A read of the address being written returns the write data.

`timescale 1ns/1ps

module yarvi_regfile #(
  parameter int xlen = 64
) (
  input  logic             clock,
  input  logic             arst_n,
  input  logic             we,
  input  logic [4:0]       waddr,
  input  logic [4:0]       raddr1,
  input  logic [4:0]       raddr2,
  input  logic [xlen-1:0]  wdata,
  output logic [xlen-1:0]  rdata1,
  output logic [xlen-1:0]  rdata2
);

  // No storage for x0.
  logic [xlen-1:0] regs [1:31];

  // Write enable qualified so that x0 stays zero.
  logic wr_hit;

  assign wr_hit = we && (waddr != 5'd0);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_hit) begin
      regs[waddr] <= wdata;
    end
  end

  // Read priority is x0, then write bypass, then storage.
  function automatic logic [xlen-1:0] read_port(input logic [4:0] addr);
    logic [xlen-1:0] val;
    if (addr == 5'd0)
      val = '0;
    else if (wr_hit && waddr == addr)
      val = wdata;
    else
      val = regs[addr];
    return val;
  endfunction

  always_comb begin
    rdata1 = read_port(raddr1);
    rdata2 = read_port(raddr2);
  end

endmodule

// ==== logic/yarvi_exec.sv ====
// Integer execute path top level.
// One instruction per cycle, no handshake; results appear one cycle later.
// Write-back to the register file happens from the registered wb_* outputs.
// xlen must be 32 or 64.

`timescale 1ns/1ps

module yarvi_exec #(
  parameter int xlen = yarvi_pkg::default_xlen
) (
  input  logic             clock,
  input  logic             arst_n,
  input  logic             insn_valid,
  input  logic [31:0]      insn,
  output logic             wb_valid,
  output logic [4:0]       wb_rd,
  output logic [xlen-1:0]  wb_value,
  output logic             illegal
);
  import yarvi_pkg::*;

  // Decode outputs.
  logic [4:0]       rs1;
  logic [4:0]       rs2;
  logic [4:0]       rd;
  alu_fn_e          fn;
  logic             alt;
  logic             w;
  logic             use_imm;
  logic             is_lui;
  logic             bad;
  logic [xlen-1:0]  imm;

  // Datapath.
  logic [xlen-1:0]  rdata1;
  logic [xlen-1:0]  rdata2;
  logic [xlen-1:0]  op1;
  logic [xlen-1:0]  op2;
  logic [xlen-1:0]  result;

  yarvi_decode #(.xlen(xlen)) u_decode (
    .insn    (insn),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .fn      (fn),
    .alt     (alt),
    .w       (w),
    .use_imm (use_imm),
    .is_lui  (is_lui),
    .bad     (bad),
    .imm     (imm)
  );

  // Written from last cycle's result, bypassed on reads.
  yarvi_regfile #(.xlen(xlen)) u_regfile (
    .clock  (clock),
    .arst_n (arst_n),
    .we     (wb_valid),
    .waddr  (wb_rd),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .wdata  (wb_value),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  // LUI adds its immediate to zero.
  assign op1 = is_lui ? '0 : rdata1;
  assign op2 = use_imm ? imm : rdata2;

  yarvi_alu #(.xlen(xlen)) u_alu (
    .insn30 (alt),
    .fn     (fn),
    .w      (w),
    .op1    (op1),
    .op2    (op2),
    .result (result)
  );

  // Status pulses, one cycle each.
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      wb_valid <= 1'b0;
      illegal  <= 1'b0;
    end else begin
      wb_valid <= insn_valid & ~bad;
      illegal  <= insn_valid & bad;
    end
  end

  // Payload, only meaningful while wb_valid.
  always_ff @(posedge clock) begin
    if (insn_valid) begin
      wb_rd    <= rd;
      wb_value <= result;
    end
  end

endmodule

// ==== verification/yarvi_exec_checker.sv ====
// Assertion checker bound into every yarvi_exec instance.
// Keeps a shadow register file fed by its own predicted write-back.
// Predictions follow the RISC-V rules for OP, OP-IMM, LUI and the W forms.
// fail_count holds the number of failed assertions.

`timescale 1ns/1ps

module yarvi_exec_checker #(
  parameter int xlen = 64
) (
  input logic             clock,
  input logic             arst_n,
  input logic             insn_valid,
  input logic [31:0]      insn,
  input logic             wb_valid,
  input logic [4:0]       wb_rd,
  input logic [xlen-1:0]  wb_value,
  input logic             illegal
);
  import yarvi_pkg::*;

  localparam int shw = $clog2(xlen);

  int fail_count = 0;

  // Shadow registers; x0 is never written.
  logic [xlen-1:0] shadow [0:31];

  // Expected outputs for the current cycle.
  logic            exp_valid;
  logic            exp_illegal;
  logic [4:0]      exp_rd;
  logic [xlen-1:0] exp_value;

  // Encoding legality per the ISA subset.
  function automatic logic legal(input logic [31:0] i);
    logic [2:0] f3;
    logic [6:0] f7;
    logic       w_shift_ok;
    logic       ok;
    f3 = i[14:12];
    f7 = i[31:25];
    w_shift_ok = (f3 == 3'd1 && f7 == 7'h00) ||
                 (f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20));
    case (i[6:0])
      OPC_LUI: ok = 1'b1;
      OPC_OP:  ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      OPC_OP_IMM: begin
        if (f3 == 3'd1)
          ok = (xlen == 64) ? (i[31:26] == 6'h00) : (f7 == 7'h00);
        else if (f3 == 3'd5)
          ok = (xlen == 64) ? (i[31:26] == 6'h00 || i[31:26] == 6'h10)
                            : (f7 == 7'h00 || f7 == 7'h20);
        else
          ok = 1'b1;
      end
      OPC_OP_32:     ok = (xlen == 64) &&
                          (w_shift_ok || (f3 == 3'd0 && (f7 == 7'h00 || f7 == 7'h20)));
      OPC_OP_IMM_32: ok = (xlen == 64) && (w_shift_ok || f3 == 3'd0);
      default:       ok = 1'b0;
    endcase
    return ok;
  endfunction

  // Result of a legal instruction from its two source values.
  function automatic logic [xlen-1:0] compute(input logic [31:0] i,
                                              input logic [xlen-1:0] a,
                                              input logic [xlen-1:0] b);
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] r;
    logic [31:0]     wr;
    logic            reg_form;
    int              sh;
    imm_i    = xlen'($signed(i[31:20]));
    reg_form = (i[6:0] == OPC_OP) || (i[6:0] == OPC_OP_32);
    src2     = reg_form ? b : imm_i;
    r        = '0;
    wr       = '0;
    case (i[6:0])
      OPC_LUI: r = xlen'($signed({i[31:12], 12'h000}));
      OPC_OP, OPC_OP_IMM: begin
        sh = int'(src2[shw-1:0]);
        case (i[14:12])
          3'd0: r = (reg_form && i[30]) ? a - src2 : a + src2;
          3'd1: r = a << sh;
          3'd2: r = xlen'($signed(a) < $signed(src2));
          3'd3: r = xlen'(a < src2);
          3'd4: r = a ^ src2;
          3'd5: begin
            if (i[30])
              r = $signed(a) >>> sh;
            else
              r = a >> sh;
          end
          3'd6: r = a | src2;
          default: r = a & src2;
        endcase
      end
      OPC_OP_32, OPC_OP_IMM_32: begin
        // Low word only, then sign-extend from bit 31.
        sh = int'(src2[4:0]);
        case (i[14:12])
          3'd0: wr = (reg_form && i[30]) ? a[31:0] - src2[31:0] : a[31:0] + src2[31:0];
          3'd1: wr = a[31:0] << sh;
          default: begin
            if (i[30])
              wr = $signed(a[31:0]) >>> sh;
            else
              wr = a[31:0] >> sh;
          end
        endcase
        r = xlen'($signed(wr));
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  // Source read that sees the write-back retiring at this edge.
  function automatic logic [xlen-1:0] operand(input logic [4:0] idx);
    logic [xlen-1:0] v;
    if (idx == 5'd0)
      v = '0;
    else if (exp_valid && exp_rd == idx)
      v = exp_value;
    else
      v = shadow[idx];
    return v;
  endfunction

  always @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      exp_valid   <= 1'b0;
      exp_illegal <= 1'b0;
      exp_rd      <= '0;
      exp_value   <= '0;
      for (int k = 0; k < 32; k++) begin
        shadow[k] <= '0;
      end
    end else begin
      // Retire the previous prediction.
      if (exp_valid && exp_rd != 5'd0) begin
        shadow[exp_rd] <= exp_value;
      end
      exp_valid   <= insn_valid && legal(insn);
      exp_illegal <= insn_valid && !legal(insn);
      if (insn_valid) begin
        exp_rd    <= insn[11:7];
        exp_value <= compute(insn, operand(insn[19:15]), operand(insn[24:20]));
      end
    end
  end

  a_wb_valid: assert property (@(posedge clock) disable iff (!arst_n)
    wb_valid == exp_valid)
    else begin
      fail_count++;
      $error("MISMATCH t=%0t wb_valid exp=%0b got=%0b",
             $time, $sampled(exp_valid), $sampled(wb_valid));
    end

  a_illegal: assert property (@(posedge clock) disable iff (!arst_n)
    illegal == exp_illegal)
    else begin
      fail_count++;
      $error("MISMATCH t=%0t illegal exp=%0b got=%0b",
             $time, $sampled(exp_illegal), $sampled(illegal));
    end

  a_wb_rd: assert property (@(posedge clock) disable iff (!arst_n)
    exp_valid |-> wb_rd == exp_rd)
    else begin
      fail_count++;
      $error("MISMATCH t=%0t wb_rd exp=%0d got=%0d",
             $time, $sampled(exp_rd), $sampled(wb_rd));
    end

  a_wb_value: assert property (@(posedge clock) disable iff (!arst_n)
    exp_valid |-> wb_value == exp_value)
    else begin
      fail_count++;
      $error("MISMATCH t=%0t wb_value exp=%h got=%h",
             $time, $sampled(exp_value), $sampled(wb_value));
    end

endmodule

bind yarvi_exec yarvi_exec_checker #(.xlen(xlen)) u_checker (.*);

// ==== verification/yarvi_exec_tb.sv ====
// Testbench for yarvi_exec at xlen 64.
// Checking happens in the bound checker; results are read from its fail_count.
// The watchdog budget follows the per-test instruction counts below.

`timescale 1ns/1ps

module yarvi_exec_tb;
  import yarvi_pkg::*;

  localparam int xlen = 64;

  // Instructions per test, bubbles included.
  localparam int n_reset     = 4;
  localparam int n_reg_reg   = 70;
  localparam int n_imm       = 28;
  localparam int n_word      = 15;
  localparam int n_illegal   = 14;
  localparam int total_insns = n_reset + n_reg_reg + n_imm + n_word + n_illegal;

  logic             clock;
  logic             arst_n;
  logic             insn_valid;
  logic [31:0]      insn;
  logic             wb_valid;
  logic [4:0]       wb_rd;
  logic [xlen-1:0]  wb_value;
  logic             illegal;

  logic [31:0] rng_state;
  int          issued;
  int          test_start;
  int          tests_run;
  int          tests_failed;
  int          last_fails;

  yarvi_exec #(.xlen(xlen)) dut (
    .clock      (clock),
    .arst_n     (arst_n),
    .insn_valid (insn_valid),
    .insn       (insn),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_value   (wb_value),
    .illegal    (illegal)
  );

  always #10 clock = ~clock;

  // 32-bit xorshift generator.
  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Register index in first .. first+count-1.
  function automatic logic [4:0] random_reg(input int first, input int count);
    return 5'(first + xorshift() % count);
  endfunction

  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'(OPC_LUI)};
  endfunction

  // Op table: ADD SUB SLL SLT SLTU XOR SRL SRA OR AND.
  function automatic logic [31:0] rr_insn(input int op, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [4:0] rd,
                                          input logic [6:0] opc);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = (op == 1 || op == 7) ? 7'h20 : 7'h00;
    case (op)
      0, 1:    f3 = 3'd0;
      2:       f3 = 3'd1;
      3:       f3 = 3'd2;
      4:       f3 = 3'd3;
      5:       f3 = 3'd4;
      6, 7:    f3 = 3'd5;
      8:       f3 = 3'd6;
      default: f3 = 3'd7;
    endcase
    return rtype(f7, rs2, rs1, f3, rd, opc);
  endfunction

  task automatic issue(input logic [31:0] word);
    @(posedge clock);
    insn_valid <= 1'b1;
    insn       <= word;
    issued++;
  endtask

  // Idle cycle with junk on insn.
  task automatic bubble(input logic [31:0] word);
    @(posedge clock);
    insn_valid <= 1'b0;
    insn       <= word;
    issued++;
  endtask

  // Five instructions; x31 is scratch.
  task automatic load_random(input logic [4:0] rd);
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] mix;
    hi  = xorshift();
    lo  = xorshift();
    mix = xorshift();
    issue(utype(hi[19:0], rd));
    issue(itype(lo[11:0], rd, 3'd0, rd, OPC_OP_IMM));
    issue(itype(12'd32, rd, 3'd1, rd, OPC_OP_IMM));
    issue(utype(mix[19:0], 5'd31));
    issue(rtype(7'h00, 5'd31, rd, 3'd4, rd, OPC_OP));
  endtask

  // Drain the last result and report the test.
  task automatic end_test(input string name);
    int delta;
    int n;
    @(posedge clock);
    insn_valid <= 1'b0;
    @(posedge clock);
    #1;
    delta = dut.u_checker.fail_count - last_fails;
    last_fails = dut.u_checker.fail_count;
    n = issued - test_start;
    test_start = issued;
    tests_run++;
    if (delta != 0)
      tests_failed++;
    $display("test %-14s %3d instructions, %0d assertion failures", name, n, delta);
  endtask

  task automatic reset_state();
    issue(utype(20'habcde, 5'd1));
    issue(itype(12'hffb, 5'd0, 3'd0, 5'd2, OPC_OP_IMM));
    issue(itype(12'h7ff, 5'd0, 3'd0, 5'd3, OPC_OP_IMM));
    issue(utype(20'h80000, 5'd4));
    end_test("reset_state");
  endtask

  task automatic reg_reg_ops();
    for (int k = 1; k <= 8; k++) begin
      load_random(5'(k));
    end
    for (int round = 0; round < 3; round++) begin
      for (int op = 0; op < 10; op++) begin
        issue(rr_insn(op, random_reg(1, 8), random_reg(1, 8), random_reg(9, 7), OPC_OP));
      end
    end
    end_test("reg_reg");
  endtask

  task automatic imm_ops();
    logic [5:0] amt;
    for (int round = 0; round < 2; round++) begin
      for (int f = 0; f < 8; f++) begin
        // Shifts are covered below.
        if (f != 1 && f != 5)
          issue(itype(12'(xorshift()), random_reg(1, 15), 3'(f), random_reg(16, 8),
                      OPC_OP_IMM));
      end
    end
    for (int k = 0; k < 3; k++) begin
      amt = (k == 0) ? 6'd0 : (k == 1) ? 6'd63 : 6'(xorshift());
      issue(itype({6'h00, amt}, random_reg(1, 8), 3'd1, 5'd16, OPC_OP_IMM));
      issue(itype({6'h00, amt}, random_reg(1, 8), 3'd5, 5'd17, OPC_OP_IMM));
      issue(itype({6'h10, amt}, random_reg(1, 8), 3'd5, 5'd18, OPC_OP_IMM));
    end
    issue(utype(20'(xorshift()), 5'd22));
    issue(utype(20'(xorshift()), 5'd23));
    // Each instruction reads the previous result.
    for (int k = 0; k < 4; k++) begin
      issue(itype(12'(xorshift()), 5'd20, 3'd0, 5'd20, OPC_OP_IMM));
    end
    issue(rtype(7'h00, 5'd20, 5'd20, 3'd0, 5'd21, OPC_OP));
    end_test("imm_lui_chain");
  endtask

  task automatic word_ops();
    int pick [5] = '{0, 1, 2, 6, 7};
    for (int round = 0; round < 2; round++) begin
      for (int k = 0; k < 5; k++) begin
        issue(rr_insn(pick[k], random_reg(1, 8), random_reg(1, 8), random_reg(24, 5),
                      OPC_OP_32));
      end
    end
    issue(itype(12'(xorshift()), random_reg(1, 8), 3'd0, 5'd29, OPC_OP_IMM_32));
    issue(itype(12'(xorshift()), random_reg(1, 8), 3'd0, 5'd30, OPC_OP_IMM_32));
    issue(itype({7'h00, 5'(xorshift())}, random_reg(1, 8), 3'd1, 5'd24, OPC_OP_IMM_32));
    issue(itype({7'h00, 5'(xorshift())}, random_reg(1, 8), 3'd5, 5'd25, OPC_OP_IMM_32));
    issue(itype({7'h20, 5'(xorshift())}, random_reg(1, 8), 3'd5, 5'd26, OPC_OP_IMM_32));
    end_test("word_ops");
  endtask

  task automatic x0_and_illegal();
    issue(itype(12'd5, 5'd1, 3'd0, 5'd0, OPC_OP_IMM));
    issue(rtype(7'h00, 5'd0, 5'd0, 3'd0, 5'd5, OPC_OP));
    issue(utype(20'(xorshift()), 5'd0));
    issue(rtype(7'h00, 5'd1, 5'd0, 3'd0, 5'd6, OPC_OP));
    // Load, MUL, bad SLLI, bad OP-32, bad OP-IMM-32, bad funct7, all ones.
    issue(32'h0000_b083);
    issue(rtype(7'h01, 5'd3, 5'd1, 3'd0, 5'd2, OPC_OP));
    issue(itype({6'h20, 6'd3}, 5'd1, 3'd1, 5'd3, OPC_OP_IMM));
    issue(rtype(7'h00, 5'd2, 5'd1, 3'd2, 5'd4, OPC_OP_32));
    issue(itype(12'h000, 5'd1, 3'd4, 5'd4, OPC_OP_IMM_32));
    issue(rtype(7'h20, 5'd2, 5'd1, 3'd4, 5'd5, OPC_OP));
    issue(32'hffff_ffff);
    bubble(xorshift());
    // Registers named by the illegal words must be unchanged.
    issue(rtype(7'h00, 5'd2, 5'd1, 3'd0, 5'd7, OPC_OP));
    issue(rtype(7'h00, 5'd4, 5'd5, 3'd6, 5'd8, OPC_OP));
    end_test("x0_illegal");
  endtask

  initial begin
    clock        = 1'b0;
    arst_n       = 1'b0;
    insn_valid   = 1'b0;
    insn         = '0;
    rng_state    = 32'd12208;
    issued       = 0;
    test_start   = 0;
    tests_run    = 0;
    tests_failed = 0;
    last_fails   = 0;
    repeat (3) @(posedge clock);
    arst_n <= 1'b1;
    reset_state();
    reg_reg_ops();
    imm_ops();
    word_ops();
    x0_and_illegal();
    $display("tests run: %0d, tests failed: %0d, assertion failures: %0d",
             tests_run, tests_failed, dut.u_checker.fail_count);
    if (tests_failed == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // One clock per instruction plus reset and drain slack.
  initial begin
    #((total_insns + 20) * 20);
    $display("watchdog expired before all tests finished");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== yarvi_exec.f ====
logic/yarvi_pkg.sv
logic/yarvi_alu.sv
logic/yarvi_decode.sv
logic/yarvi_regfile.sv
logic/yarvi_exec.sv
verification/yarvi_exec_checker.sv
verification/yarvi_exec_tb.sv

// ==== Bender.yml ====
package:
  name: yarvi_exec

sources:
  # RTL in compile order.
  - logic/yarvi_pkg.sv
  - logic/yarvi_alu.sv
  - logic/yarvi_decode.sv
  - logic/yarvi_regfile.sv
  - logic/yarvi_exec.sv

  # Verification sources.
  - target: test
    files:
      - verification/yarvi_exec_checker.sv
      - verification/yarvi_exec_tb.sv
